// File: rtl/token_engine_pkg.sv
// shared widths and encodings; weight bytes are packed little endian, byte 0 in the low bits
`default_nettype none

package token_engine_pkg;

    localparam int ADDR_W         = 32; // GLB byte address
    localparam int DATA_W         = 32; // GLB word
    localparam int BYTES_PER_WORD = 4;

    // one GLB word, seen whole for ifmap/opsum or as weight bytes
    typedef union packed {
        logic [DATA_W-1:0]              word;
        logic [BYTES_PER_WORD-1:0][7:0] bytes; // bytes[0] is the LSB
    } glb_word_t;

    // pass sequencing
    typedef enum logic [1:0] {
        IDLE,
        WEIGHT,
        STREAM,
        DONE
    } pass_state_e;

    // owner of a GLB access, kept by the arbiter to steer read data
    typedef enum logic [1:0] {
        WEIGHT_SRC,
        OPSUM_SRC,
        IFMAP_SRC
    } req_src_e;

endpackage

`default_nettype wire

// File: rtl/pass_sequencer.sv
// pointwise passes only; a pass_start_i outside IDLE is dropped, not queued
`default_nettype none

module pass_sequencer import token_engine_pkg::*; (
    input  logic clk,
    input  logic reset_i,
    input  logic pass_start_i,
    input  logic weight_done_i,
    input  logic feed_done_i,
    input  logic drain_done_i,
    output logic weight_state_o,
    output logic stream_state_o,
    output logic pass_done_o
);

    pass_state_e state_q;
    pass_state_e state_d;
    logic        feed_seen_q;  // feeder finished earlier in this STREAM
    logic        drain_seen_q;
    logic        feed_ok;
    logic        drain_ok;

    // the done pulses may land in different cycles
    assign feed_ok  = feed_seen_q || feed_done_i;
    assign drain_ok = drain_seen_q || drain_done_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (pass_start_i) begin
                    state_d = WEIGHT;
                end
            end
            WEIGHT: begin
                if (weight_done_i) begin
                    state_d = STREAM;
                end
            end
            STREAM: begin
                if (feed_ok && drain_ok) begin
                    state_d = DONE;
                end
            end
            default: begin
                state_d = IDLE; // DONE holds one cycle only
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q      <= IDLE;
            feed_seen_q  <= 1'b0;
            drain_seen_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            feed_seen_q  <= (state_q == STREAM) && feed_ok;  // cleared outside STREAM
            drain_seen_q <= (state_q == STREAM) && drain_ok;
        end
    end

    assign weight_state_o = (state_q == WEIGHT);
    assign stream_state_o = (state_q == STREAM);
    assign pass_done_o    = (state_q == DONE);

endmodule

`default_nettype wire

// File: rtl/weight_loader.sv
// one read in flight at a time; each word costs a read plus four byte cycles
`default_nettype none

module weight_loader import token_engine_pkg::*; #(
    parameter int LEN_W = 16
) (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              weight_state_i,
    input  logic [ADDR_W-1:0] weight_base_i,  // byte address
    input  logic [LEN_W-1:0]  weight_words_i,
    input  logic              grant_i,
    input  logic              rdata_valid_i,
    input  logic [DATA_W-1:0] glb_read_data_i,
    output logic              req_o,
    output logic [ADDR_W-1:0] addr_o,
    output logic [7:0]        weight_o,
    output logic              weight_valid_o,
    output logic              weight_done_o
);

    localparam int BYTE_W = $clog2(BYTES_PER_WORD);

    logic [LEN_W-1:0]  word_cnt_q; // words granted so far
    logic [BYTE_W-1:0] byte_cnt_q;
    logic              wait_q;     // read granted, data not back yet
    logic              emit_q;     // bytes of word_q going out
    glb_word_t         word_q;
    logic              idle;

    assign idle   = weight_state_i && !wait_q && !emit_q;
    assign req_o  = idle && (word_cnt_q != weight_words_i);
    assign addr_o = weight_base_i + ADDR_W'(word_cnt_q) * ADDR_W'(BYTES_PER_WORD);

    assign weight_o       = word_q.bytes[byte_cnt_q];
    assign weight_valid_o = emit_q;
    assign weight_done_o  = idle && (word_cnt_q == weight_words_i); // cycle after last byte

    always_ff @(posedge clk) begin
        if (reset_i || !weight_state_i) begin
            word_cnt_q <= '0;
            byte_cnt_q <= '0;
            wait_q     <= 1'b0;
            emit_q     <= 1'b0;
        end else begin
            if (grant_i) begin
                word_cnt_q <= word_cnt_q + 1'b1;
                wait_q     <= 1'b1;
            end
            if (rdata_valid_i) begin
                wait_q     <= 1'b0;
                emit_q     <= 1'b1;
                byte_cnt_q <= '0;
            end else if (emit_q) begin
                byte_cnt_q <= byte_cnt_q + 1'b1;
                if (byte_cnt_q == BYTE_W'(BYTES_PER_WORD - 1)) begin
                    emit_q <= 1'b0; // last byte of this word
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdata_valid_i) begin
            word_q.word <= glb_read_data_i;
        end
    end

endmodule

`default_nettype wire

// File: rtl/ifmap_lane_feeder.sv
// credits reload on every cycle outside STREAM, so lane FIFOs must be drained between passes
`default_nettype none

module ifmap_lane_feeder import token_engine_pkg::*; #(
    parameter int NUM_LANES    = 4,
    parameter int LANE_CREDITS = 4,
    parameter int LEN_W        = 16
) (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic                              stream_state_i,
    input  logic [ADDR_W-1:0]                 ifmap_base_i,  // byte address
    input  logic [LEN_W-1:0]                  ifmap_len_i,   // words per lane
    input  logic                              grant_i,
    input  logic                              rdata_valid_i,
    input  logic [DATA_W-1:0]                 glb_read_data_i,
    input  logic [NUM_LANES-1:0]              ifmap_credit_return_i,
    output logic                              req_o,
    output logic [ADDR_W-1:0]                 addr_o,
    output logic [NUM_LANES-1:0]              ifmap_push_o,
    output logic [NUM_LANES-1:0][DATA_W-1:0]  ifmap_push_data_o,
    output logic                              feed_done_o
);

    localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
    localparam int CRED_W = $clog2(LANE_CREDITS + 1);

    logic [NUM_LANES-1:0][CRED_W-1:0] credit_q;
    logic [NUM_LANES-1:0][LEN_W-1:0]  cnt_q;    // reads granted per lane
    logic [NUM_LANES-1:0]             elig;
    logic [LANE_W-1:0]                rr_q;     // round-robin start lane
    logic [LANE_W-1:0]                sel;
    logic [LANE_W-1:0]                pend_lane_q; // lane of the read now returning
    logic                             all_issued;
    logic                             fed_q;

    always_comb begin
        int idx;
        all_issued = 1'b1;
        sel        = rr_q;
        req_o      = 1'b0;
        for (int l = 0; l < NUM_LANES; l++) begin
            elig[l]    = stream_state_i && (credit_q[l] != '0) && (cnt_q[l] != ifmap_len_i);
            all_issued = all_issued && (cnt_q[l] == ifmap_len_i);
        end
        for (int i = 0; i < NUM_LANES; i++) begin
            idx = (int'(rr_q) + i) % NUM_LANES;
            if (!req_o && elig[idx]) begin
                sel   = LANE_W'(idx);
                req_o = 1'b1;
            end
        end
    end

    // lane-major layout: lane l starts at base + l * len words
    assign addr_o = ifmap_base_i
                  + (ADDR_W'(sel) * ADDR_W'(ifmap_len_i) + ADDR_W'(cnt_q[sel]))
                  * ADDR_W'(BYTES_PER_WORD);

    assign ifmap_push_o      = rdata_valid_i ? (NUM_LANES'(1) << pend_lane_q) : '0;
    assign ifmap_push_data_o = {NUM_LANES{glb_read_data_i}}; // push picks the lane
    assign feed_done_o       = stream_state_i && all_issued && !rdata_valid_i && !fed_q;

    always_ff @(posedge clk) begin
        if (reset_i || !stream_state_i) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                credit_q[l] <= CRED_W'(LANE_CREDITS);
                cnt_q[l]    <= '0;
            end
            rr_q  <= '0;
            fed_q <= 1'b0;
        end else begin
            for (int l = 0; l < NUM_LANES; l++) begin
                credit_q[l] <= credit_q[l] + CRED_W'(ifmap_credit_return_i[l])
                             - CRED_W'(grant_i && (sel == LANE_W'(l)));
            end
            if (grant_i) begin
                cnt_q[sel] <= cnt_q[sel] + 1'b1;
                rr_q       <= (sel == LANE_W'(NUM_LANES - 1)) ? '0 : sel + 1'b1;
            end
            if (feed_done_o) begin
                fed_q <= 1'b1; // one pulse per pass
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant_i) begin
            pend_lane_q <= sel;
        end
    end

endmodule

`default_nettype wire

// File: rtl/opsum_drainer.sv
// lowest ready lane wins, so a busy low lane can starve higher lanes until it runs dry
`default_nettype none

module opsum_drainer import token_engine_pkg::*; #(
    parameter int NUM_LANES = 4,
    parameter int LEN_W     = 16
) (
    input  logic                             clk,
    input  logic                             reset_i,
    input  logic                             stream_state_i,
    input  logic [ADDR_W-1:0]                opsum_base_i,  // byte address
    input  logic [LEN_W-1:0]                 opsum_len_i,   // words per lane
    input  logic                             grant_i,
    input  logic [NUM_LANES-1:0]             opsum_valid_i, // FWFT not-empty
    input  logic [NUM_LANES-1:0][DATA_W-1:0] opsum_data_i,
    output logic                             req_o,
    output logic [ADDR_W-1:0]                addr_o,
    output logic [DATA_W-1:0]                wdata_o,
    output logic [NUM_LANES-1:0]             opsum_pop_o,
    output logic                             drain_done_o
);

    localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [NUM_LANES-1:0][LEN_W-1:0] cnt_q; // words written per lane
    logic [NUM_LANES-1:0]            elig;
    logic [LANE_W-1:0]               sel;
    logic                            all_done;
    logic                            drained_q;

    always_comb begin
        sel      = '0;
        all_done = 1'b1;
        for (int l = NUM_LANES - 1; l >= 0; l--) begin
            elig[l]  = stream_state_i && opsum_valid_i[l] && (cnt_q[l] != opsum_len_i);
            all_done = all_done && (cnt_q[l] == opsum_len_i);
            if (elig[l]) begin
                sel = LANE_W'(l); // ends on the lowest one
            end
        end
    end

    assign req_o   = |elig;
    assign addr_o  = opsum_base_i
                   + (ADDR_W'(sel) * ADDR_W'(opsum_len_i) + ADDR_W'(cnt_q[sel]))
                   * ADDR_W'(BYTES_PER_WORD);
    assign wdata_o = opsum_data_i[sel];

    // the write happens in the grant cycle, so pop right then
    assign opsum_pop_o  = grant_i ? (NUM_LANES'(1) << sel) : '0;
    assign drain_done_o = stream_state_i && all_done && !drained_q;

    always_ff @(posedge clk) begin
        if (reset_i || !stream_state_i) begin
            cnt_q     <= '0;
            drained_q <= 1'b0;
        end else begin
            if (grant_i) begin
                cnt_q[sel] <= cnt_q[sel] + 1'b1;
            end
            if (drain_done_o) begin
                drained_q <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/glb_arbiter.sv
// fixed priority weight > opsum > ifmap; relies on a GLB read latency of exactly one cycle
`default_nettype none

module glb_arbiter import token_engine_pkg::*; (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      weight_req_i,
    input  logic [ADDR_W-1:0]         weight_addr_i,
    input  logic                      opsum_req_i,
    input  logic [ADDR_W-1:0]         opsum_addr_i,
    input  logic [DATA_W-1:0]         opsum_wdata_i,
    input  logic                      ifmap_req_i,
    input  logic [ADDR_W-1:0]         ifmap_addr_i,
    output logic                      weight_grant_o,
    output logic                      opsum_grant_o,
    output logic                      ifmap_grant_o,
    output logic                      weight_rdata_valid_o,
    output logic                      ifmap_rdata_valid_o,
    output logic                      glb_read_o,
    output logic [ADDR_W-1:0]         glb_addr_o,
    output logic [BYTES_PER_WORD-1:0] glb_web_o,
    output logic [DATA_W-1:0]         glb_write_data_o
);

    req_src_e src;    // owner of this cycle's access
    req_src_e src_q;
    logic     acc_q;  // an access took place last cycle

    assign weight_grant_o = weight_req_i;
    assign opsum_grant_o  = opsum_req_i && !weight_req_i;
    assign ifmap_grant_o  = ifmap_req_i && !weight_req_i && !opsum_req_i;

    always_comb begin
        if (weight_req_i) begin
            src        = WEIGHT_SRC;
            glb_addr_o = weight_addr_i;
        end else if (opsum_req_i) begin
            src        = OPSUM_SRC;
            glb_addr_o = opsum_addr_i;
        end else begin
            src        = IFMAP_SRC;
            glb_addr_o = ifmap_addr_i;
        end
    end

    assign glb_read_o       = weight_grant_o || ifmap_grant_o;
    assign glb_web_o        = opsum_grant_o ? '1 : '0; // full word write
    assign glb_write_data_o = opsum_wdata_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            acc_q <= 1'b0;
            src_q <= IFMAP_SRC;
        end else begin
            acc_q <= weight_req_i || opsum_req_i || ifmap_req_i;
            src_q <= src;
        end
    end

    // a write leaves OPSUM_SRC behind and steers no data
    assign weight_rdata_valid_o = acc_q && (src_q == WEIGHT_SRC);
    assign ifmap_rdata_valid_o  = acc_q && (src_q == IFMAP_SRC);

endmodule

`default_nettype wire

// File: rtl/token_engine.sv
// base addresses come in as word addresses; lane FIFOs are outside and must be empty at pass start
`default_nettype none

module token_engine import token_engine_pkg::*; #(
    parameter int NUM_LANES    = 4,
    parameter int LANE_CREDITS = 4,
    parameter int LEN_W        = 16
) (
    input  logic                             clk,
    input  logic                             reset_i,
    input  logic                             pass_start_i,
    output logic                             pass_done_o,
    input  logic [ADDR_W-1:0]                weight_base_i,
    input  logic [ADDR_W-1:0]                ifmap_base_i,
    input  logic [ADDR_W-1:0]                opsum_base_i,
    input  logic [LEN_W-1:0]                 weight_words_i,
    input  logic [LEN_W-1:0]                 ifmap_len_i,
    input  logic [LEN_W-1:0]                 opsum_len_i,
    input  logic [DATA_W-1:0]                glb_read_data_i,
    output logic                             glb_read_o,
    output logic [ADDR_W-1:0]                glb_addr_o,
    output logic [BYTES_PER_WORD-1:0]        glb_web_o,
    output logic [DATA_W-1:0]                glb_write_data_o,
    output logic [7:0]                       weight_o,
    output logic                             weight_valid_o,
    output logic [NUM_LANES-1:0]             ifmap_push_o,
    output logic [NUM_LANES-1:0][DATA_W-1:0] ifmap_push_data_o,
    input  logic [NUM_LANES-1:0]             ifmap_credit_return_i,
    input  logic [NUM_LANES-1:0]             opsum_valid_i,
    input  logic [NUM_LANES-1:0][DATA_W-1:0] opsum_data_i,
    output logic [NUM_LANES-1:0]             opsum_pop_o
);

    logic [ADDR_W-1:0] weight_base_b, ifmap_base_b, opsum_base_b; // byte addresses
    logic weight_state, stream_state;
    logic weight_done, feed_done, drain_done;
    logic weight_req, weight_grant, weight_rvalid;
    logic ifmap_req, ifmap_grant, ifmap_rvalid;
    logic opsum_req, opsum_grant;
    logic [ADDR_W-1:0] weight_addr, ifmap_addr, opsum_addr;
    logic [DATA_W-1:0] opsum_wdata;

    assign weight_base_b = weight_base_i << 2; // word -> byte
    assign ifmap_base_b  = ifmap_base_i << 2;
    assign opsum_base_b  = opsum_base_i << 2;

    pass_sequencer u_seq (
        .clk(clk), .reset_i(reset_i), .pass_start_i(pass_start_i),
        .weight_done_i(weight_done), .feed_done_i(feed_done), .drain_done_i(drain_done),
        .weight_state_o(weight_state), .stream_state_o(stream_state),
        .pass_done_o(pass_done_o)
    );

    weight_loader #(.LEN_W(LEN_W)) u_weight (
        .clk(clk), .reset_i(reset_i), .weight_state_i(weight_state),
        .weight_base_i(weight_base_b), .weight_words_i(weight_words_i),
        .grant_i(weight_grant), .rdata_valid_i(weight_rvalid),
        .glb_read_data_i(glb_read_data_i), .req_o(weight_req), .addr_o(weight_addr),
        .weight_o(weight_o), .weight_valid_o(weight_valid_o), .weight_done_o(weight_done)
    );

    ifmap_lane_feeder #(
        .NUM_LANES(NUM_LANES), .LANE_CREDITS(LANE_CREDITS), .LEN_W(LEN_W)
    ) u_ifmap (
        .clk(clk), .reset_i(reset_i), .stream_state_i(stream_state),
        .ifmap_base_i(ifmap_base_b), .ifmap_len_i(ifmap_len_i),
        .grant_i(ifmap_grant), .rdata_valid_i(ifmap_rvalid),
        .glb_read_data_i(glb_read_data_i), .ifmap_credit_return_i(ifmap_credit_return_i),
        .req_o(ifmap_req), .addr_o(ifmap_addr), .ifmap_push_o(ifmap_push_o),
        .ifmap_push_data_o(ifmap_push_data_o), .feed_done_o(feed_done)
    );

    opsum_drainer #(.NUM_LANES(NUM_LANES), .LEN_W(LEN_W)) u_opsum (
        .clk(clk), .reset_i(reset_i), .stream_state_i(stream_state),
        .opsum_base_i(opsum_base_b), .opsum_len_i(opsum_len_i), .grant_i(opsum_grant),
        .opsum_valid_i(opsum_valid_i), .opsum_data_i(opsum_data_i),
        .req_o(opsum_req), .addr_o(opsum_addr), .wdata_o(opsum_wdata),
        .opsum_pop_o(opsum_pop_o), .drain_done_o(drain_done)
    );

    glb_arbiter u_arb (
        .clk(clk), .reset_i(reset_i),
        .weight_req_i(weight_req), .weight_addr_i(weight_addr),
        .opsum_req_i(opsum_req), .opsum_addr_i(opsum_addr), .opsum_wdata_i(opsum_wdata),
        .ifmap_req_i(ifmap_req), .ifmap_addr_i(ifmap_addr),
        .weight_grant_o(weight_grant), .opsum_grant_o(opsum_grant),
        .ifmap_grant_o(ifmap_grant), .weight_rdata_valid_o(weight_rvalid),
        .ifmap_rdata_valid_o(ifmap_rvalid), .glb_read_o(glb_read_o),
        .glb_addr_o(glb_addr_o), .glb_web_o(glb_web_o), .glb_write_data_o(glb_write_data_o)
    );

endmodule

`default_nettype wire

// File: verif/tb_token_engine.sv
// GLB model is 256 words, lane logs hold 16 words each; all test regions must fit inside
`default_nettype none

module tb_token_engine import token_engine_pkg::*; ();

    localparam int NUM_LANES       = 4;
    localparam int LANE_CREDITS    = 4;
    localparam int LEN_W           = 16;
    localparam int CLK_T           = 100;
    localparam int T_BASIC         = 300; // worst-case cycles per test
    localparam int T_BP            = 400;
    localparam int T_SECOND        = 300;
    localparam int WATCHDOG_CYCLES = (T_BASIC + T_BP + T_SECOND) * 2;

    logic                             clk;
    logic                             reset_i;
    logic                             pass_start_i;
    logic                             pass_done_o;
    logic [ADDR_W-1:0]                weight_base_i;
    logic [ADDR_W-1:0]                ifmap_base_i;
    logic [ADDR_W-1:0]                opsum_base_i;
    logic [LEN_W-1:0]                 weight_words_i;
    logic [LEN_W-1:0]                 ifmap_len_i;
    logic [LEN_W-1:0]                 opsum_len_i;
    logic [DATA_W-1:0]                glb_read_data_i = '0;
    logic                             glb_read_o;
    logic [ADDR_W-1:0]                glb_addr_o;
    logic [BYTES_PER_WORD-1:0]        glb_web_o;
    logic [DATA_W-1:0]                glb_write_data_o;
    logic [7:0]                       weight_o;
    logic                             weight_valid_o;
    logic [NUM_LANES-1:0]             ifmap_push_o;
    logic [NUM_LANES-1:0][DATA_W-1:0] ifmap_push_data_o;
    logic [NUM_LANES-1:0]             ifmap_credit_return_i = '0;
    logic [NUM_LANES-1:0]             opsum_valid_i = '0;
    logic [NUM_LANES-1:0][DATA_W-1:0] opsum_data_i = '0;
    logic [NUM_LANES-1:0]             opsum_pop_o;

    logic [DATA_W-1:0] mem [0:255];             // word addressed
    logic [7:0]        wlog [0:63];             // weight bytes in arrival order
    logic [DATA_W-1:0] if_log [NUM_LANES][16];  // pushed words per lane
    logic [DATA_W-1:0] os_data [NUM_LANES][16]; // opsum words queued per lane
    logic [NUM_LANES-1:0] hold;                 // lanes whose FIFO is not popped
    int if_wr [NUM_LANES];
    int if_rd [NUM_LANES];
    int os_head [NUM_LANES];
    int os_count [NUM_LANES];
    int wcnt, done_cnt, checks, errors, tests, seed;

    token_engine #(
        .NUM_LANES(NUM_LANES), .LANE_CREDITS(LANE_CREDITS), .LEN_W(LEN_W)
    ) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_T / 2) clk = ~clk;
    end

    // GLB model, one cycle read latency
    always @(posedge clk) begin
        if (glb_web_o != '0) begin
            mem[glb_addr_o[9:2]] = glb_write_data_o;
        end
        if (glb_read_o) begin
            glb_read_data_i <= mem[glb_addr_o[9:2]];
        end
    end

    // lane FIFO models and output monitors
    always @(posedge clk) begin
        logic [NUM_LANES-1:0] ret;
        ret = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
            if (ifmap_push_o[l]) begin
                if_log[l][if_wr[l]] = ifmap_push_data_o[l];
                if_wr[l]++;
            end
            if (!hold[l] && if_rd[l] < if_wr[l]) begin
                if_rd[l]++; // consumer pop frees one credit
                ret[l] = 1'b1;
            end
            if (opsum_pop_o[l]) begin
                os_head[l]++;
            end
            opsum_valid_i[l] <= os_head[l] < os_count[l]; // FWFT head
            opsum_data_i[l]  <= os_data[l][os_head[l]];
        end
        ifmap_credit_return_i <= ret;
        if (weight_valid_o) begin
            wlog[wcnt] = weight_o;
            wcnt++;
        end
        if (pass_done_o) begin
            done_cnt++;
        end
    end

    task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, name, act, exp);
        end
    endtask

    task automatic start_pass(input int wb, wn, ib, il, ob, ol);
        @(negedge clk);
        wcnt = 0;
        for (int l = 0; l < NUM_LANES; l++) begin
            if_wr[l]    = 0;
            if_rd[l]    = 0;
            os_head[l]  = 0;
            os_count[l] = ol;
            for (int k = 0; k < ol; k++) begin
                os_data[l][k] = $random(seed);
            end
        end
        @(posedge clk);
        weight_base_i  <= wb;
        weight_words_i <= wn;
        ifmap_base_i   <= ib;
        ifmap_len_i    <= il;
        opsum_base_i   <= ob;
        opsum_len_i    <= ol;
        pass_start_i   <= 1'b1;
        @(posedge clk);
        pass_start_i <= 1'b0;
    endtask

    task automatic wait_done(input int budget, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!pass_done_o && n < budget) begin
            @(negedge clk);
            n++;
        end
        if (!pass_done_o) begin
            errors++;
            $display("%s: pass did not finish within %0d cycles", what, budget);
        end
    endtask

    // called in the done cycle, so every count must already be complete
    task automatic verify_pass(input int exp_done);
        int wi;
        int base;
        check("weight byte count", wcnt, 4 * weight_words_i);
        for (int i = 0; i < wcnt && i < 64; i++) begin
            wi = weight_base_i + i / 4;
            check($sformatf("weight_o byte %0d", i), wlog[i], (mem[wi] >> (8 * (i % 4))) & 'hff);
        end
        for (int l = 0; l < NUM_LANES; l++) begin
            check($sformatf("ifmap_push_o[%0d] count", l), if_wr[l], ifmap_len_i);
            base = ifmap_base_i + l * ifmap_len_i;
            for (int k = 0; k < if_wr[l] && k < 16; k++) begin
                check($sformatf("ifmap_push_data_o[%0d] word %0d", l, k), if_log[l][k],
                      mem[base + k]);
            end
            check($sformatf("opsum_pop_o[%0d] count", l), os_head[l], opsum_len_i);
            base = opsum_base_i + l * opsum_len_i;
            for (int k = 0; k < opsum_len_i; k++) begin
                check($sformatf("opsum lane %0d word %0d", l, k), mem[base + k], os_data[l][k]);
            end
        end
        // the monitor counts this pulse only at the next edge
        check("pass_done_o pulses", done_cnt + pass_done_o, exp_done);
    endtask

    task automatic report(input string name);
        tests++;
        $display("test %s finished, %0d errors so far", name, errors);
    endtask

    task automatic test_basic();
        check("outputs after reset",
              {glb_web_o, glb_read_o, weight_valid_o, ifmap_push_o, opsum_pop_o, pass_done_o}, '0);
        start_pass(8, 3, 32, 7, 96, 3);
        wait_done(T_BASIC, "basic");
        verify_pass(1);
        report("basic");
    endtask

    task automatic test_backpressure();
        int n;
        n = 0;
        hold = 4'b0100; // lane 2 never returns credit for now
        start_pass(40, 2, 48, 6, 80, 4);
        while (!(if_wr[0] == 6 && if_wr[1] == 6 && if_wr[3] == 6) && n < T_BP) begin
            @(negedge clk);
            n++;
        end
        if (n >= T_BP) begin
            errors++;
            $display("back-pressure: lanes with credit did not finish their words");
        end
        repeat (5) @(negedge clk);
        check("held lane push count", if_wr[2], LANE_CREDITS);
        check("pass_done_o while lane held", done_cnt, 1);
        hold = '0;
        wait_done(T_BP, "back-pressure");
        verify_pass(2);
        report("backpressure");
    endtask

    task automatic test_second_pass();
        int n;
        n = 0;
        start_pass(128, 5, 160, 4, 200, 5);
        while (wcnt < 8 && n < T_SECOND) begin
            @(negedge clk);
            n++;
        end
        @(posedge clk);
        pass_start_i <= 1'b1; // mid-pass start, must be dropped
        @(posedge clk);
        pass_start_i <= 1'b0;
        wait_done(T_SECOND, "second pass");
        verify_pass(3);
        repeat (20) @(negedge clk);
        check("pass_done_o pulses after idle", done_cnt, 3);
        check("weight bytes after idle", wcnt, 20);
        report("second_pass");
    endtask

    initial begin
        seed = 87328;
        hold = '0;
        reset_i        <= 1'b1;
        pass_start_i   <= 1'b0;
        weight_base_i  <= '0;
        ifmap_base_i   <= '0;
        opsum_base_i   <= '0;
        weight_words_i <= '0;
        ifmap_len_i    <= '0;
        opsum_len_i    <= '0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = $random(seed);
        end
        repeat (3) @(posedge clk);
        reset_i <= 1'b0;
        test_basic();
        test_backpressure();
        test_second_pass();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_T);
        $display("watchdog: run went past %0d cycles and was stopped", WATCHDOG_CYCLES);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
rtl/token_engine_pkg.sv
rtl/pass_sequencer.sv
rtl/weight_loader.sv
rtl/ifmap_lane_feeder.sv
rtl/opsum_drainer.sv
rtl/glb_arbiter.sv
rtl/token_engine.sv
verif/tb_token_engine.sv

// File: Bender.yml
package:
  name: token_engine

sources:
  - rtl/token_engine_pkg.sv
  - rtl/pass_sequencer.sv
  - rtl/weight_loader.sv
  - rtl/ifmap_lane_feeder.sv
  - rtl/opsum_drainer.sv
  - rtl/glb_arbiter.sv
  - rtl/token_engine.sv
  - target: test
    files:
      - verif/tb_token_engine.sv
